/* build.f */
common/bus_pkg.sv
common/isa_pkg.sv
core/fetch_unit.sv
core/decoder.sv
core/register_file.sv
core/execute_unit.sv
core/load_store_unit.sv
design/bus_arbiter.sv
design/mini_core.sv
testbench/bus_memory_model.sv
testbench/tb_mini_core.sv

/* common/bus_pkg.sv */
`default_nettype none

package bus_pkg;

  ////////////////////
  // Bus widths
  ////////////////////

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  ////////////////////
  // Payloads
  ////////////////////

  // Request side, held stable from req until gnt
  typedef struct packed {
    logic              we;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } bus_req_t;

  // Response side, qualified by rvalid
  typedef struct packed {
    logic [DATA_W-1:0] rdata;
  } bus_rsp_t;

  // Arbiter inputs, data side has priority
  typedef enum logic {
    REQ_FETCH = 1'b0,
    REQ_DATA  = 1'b1
  } requester_e;

endpackage

`default_nettype wire

/* common/isa_pkg.sv */
`default_nettype none

package isa_pkg;

  // Register index, x0 to x31
  typedef logic [4:0] reg_addr_t;

  ////////////////////
  // Opcodes
  ////////////////////

  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011
  } opcode_e;

  // Function codes for the kept subset
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_LW      = 3'b010;
  localparam logic [2:0] F3_SW      = 3'b010;
  localparam logic [6:0] F7_ADD     = 7'b0000000;
  localparam logic [6:0] F7_SUB     = 7'b0100000;

  ////////////////////
  // ALU and decode
  ////////////////////

  typedef enum logic [1:0] {
    ALU_ADD    = 2'd0,
    ALU_SUB    = 2'd1,
    ALU_PASS_B = 2'd2
  } alu_op_e;

  // All zero means a no-op
  typedef struct packed {
    alu_op_e     alu_op;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    reg_addr_t   rd;
    logic [31:0] imm;
    logic        use_imm;
    logic        rf_we;
    logic        is_load;
    logic        is_store;
  } decoded_t;

endpackage

`default_nettype wire

/* core/decoder.sv */
`default_nettype none

module decoder (
  input  logic [31:0]       instr_i,
  output isa_pkg::decoded_t decoded_o
);
  import isa_pkg::*;

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_u;

  ////////////////////
  // Fields
  ////////////////////

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Sign-extended I and S immediates
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  // Upper 20 bits, low 12 cleared
  assign imm_u = {instr_i[31:12], 12'b0};

  ////////////////////
  // Decode
  ////////////////////

  always_comb begin
    // Default is a no-op, no write and no memory access
    decoded_o     = '0;
    decoded_o.rs1 = instr_i[19:15];
    decoded_o.rs2 = instr_i[24:20];
    decoded_o.rd  = instr_i[11:7];
    case (opcode)
      OPC_LUI: begin
        decoded_o.alu_op  = ALU_PASS_B;
        decoded_o.imm     = imm_u;
        decoded_o.use_imm = 1'b1;
        decoded_o.rf_we   = 1'b1;
      end
      OPC_OP_IMM: begin
        // ADDI only
        if (funct3 == F3_ADD_SUB) begin
          decoded_o.alu_op  = ALU_ADD;
          decoded_o.imm     = imm_i;
          decoded_o.use_imm = 1'b1;
          decoded_o.rf_we   = 1'b1;
        end
      end
      OPC_OP: begin
        if (funct3 == F3_ADD_SUB && funct7 == F7_ADD) begin
          decoded_o.alu_op = ALU_ADD;
          decoded_o.rf_we  = 1'b1;
        end else if (funct3 == F3_ADD_SUB && funct7 == F7_SUB) begin
          decoded_o.alu_op = ALU_SUB;
          decoded_o.rf_we  = 1'b1;
        end
      end
      OPC_LOAD: begin
        // Address is rs1 plus I immediate
        if (funct3 == F3_LW) begin
          decoded_o.alu_op  = ALU_ADD;
          decoded_o.imm     = imm_i;
          decoded_o.use_imm = 1'b1;
          decoded_o.rf_we   = 1'b1;
          decoded_o.is_load = 1'b1;
        end
      end
      OPC_STORE: begin
        // Address is rs1 plus S immediate, data from rs2
        if (funct3 == F3_SW) begin
          decoded_o.alu_op   = ALU_ADD;
          decoded_o.imm      = imm_s;
          decoded_o.use_imm  = 1'b1;
          decoded_o.is_store = 1'b1;
        end
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

/* core/execute_unit.sv */
`default_nettype none

module execute_unit (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               instr_valid_i,
  input  isa_pkg::decoded_t  decoded_i,
  input  logic [31:0]        rdata_a_i,
  input  logic [31:0]        rdata_b_i,
  output logic               rf_we_o,
  output isa_pkg::reg_addr_t rf_waddr_o,
  output logic [31:0]        rf_wdata_o,
  output logic               instr_done_o,
  output logic               lsu_start_o,
  output logic               lsu_store_o,
  output logic [31:0]        lsu_addr_o,
  output logic [31:0]        lsu_wdata_o,
  input  logic               lsu_done_i,
  input  logic [31:0]        lsu_rdata_i
);
  import isa_pkg::*;

  logic [31:0] operand_b;
  logic [31:0] alu_result;
  logic        is_mem;
  logic        aligned;
  logic        mem_go;
  logic        mem_busy_q;

  ////////////////////
  // ALU
  ////////////////////

  assign operand_b = decoded_i.use_imm ? decoded_i.imm : rdata_b_i;

  always_comb begin
    case (decoded_i.alu_op)
      ALU_SUB:    alu_result = rdata_a_i - operand_b;
      ALU_PASS_B: alu_result = operand_b;
      default:    alu_result = rdata_a_i + operand_b;
    endcase
  end

  ////////////////////
  // Sequencing
  ////////////////////

  // Memory ops use rs1 plus imm as byte address
  assign is_mem  = decoded_i.is_load || decoded_i.is_store;
  assign aligned = (alu_result[1:0] == 2'b00);
  // misaligned access falls through as a no-op
  assign mem_go  = is_mem && aligned;

  assign lsu_start_o = instr_valid_i && mem_go && !mem_busy_q;
  assign lsu_store_o = decoded_i.is_store;
  assign lsu_addr_o  = alu_result;
  assign lsu_wdata_o = rdata_b_i;

  // ALU ops retire at once, memory ops on lsu_done
  assign instr_done_o = mem_busy_q ? lsu_done_i : (instr_valid_i && !mem_go);

  // Write-back
  assign rf_we_o    = instr_done_o && decoded_i.rf_we && (mem_go || !is_mem);
  assign rf_waddr_o = decoded_i.rd;
  assign rf_wdata_o = decoded_i.is_load ? lsu_rdata_i : alu_result;

  // Waiting on the LSU
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mem_busy_q <= 1'b0;
    end else if (lsu_start_o) begin
      mem_busy_q <= 1'b1;
    end else if (lsu_done_i) begin
      mem_busy_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* core/fetch_unit.sv */
`default_nettype none

module fetch_unit #(
  parameter logic [bus_pkg::ADDR_W-1:0] BOOT_ADDR = '0
) (
  input  logic              clk_i,
  input  logic              reset_i,
  output logic              fetch_req_o,
  output bus_pkg::bus_req_t fetch_payload_o,
  input  logic              fetch_gnt_i,
  input  logic              fetch_rvalid_i,
  input  bus_pkg::bus_rsp_t fetch_rsp_i,
  input  logic              instr_done_i,
  output logic              instr_valid_o,
  output logic [31:0]       instr_o
);
  import bus_pkg::*;

  logic [ADDR_W-1:0] pc_q;
  logic              req_q;
  logic              pending_q;
  logic              valid_q;
  logic [31:0]       instr_q;
  logic              buf_free;
  logic              rsp_hit;

  // Buffer empty, or emptied by the retiring instruction
  assign buf_free = !valid_q || instr_done_i;
  assign rsp_hit  = pending_q && fetch_rvalid_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc_q      <= BOOT_ADDR;
      req_q     <= 1'b0;
      pending_q <= 1'b0;
      valid_q   <= 1'b0;
    end else begin
      // Handshake moves the PC on, next word is PC plus 4
      if (req_q && fetch_gnt_i) begin
        req_q     <= 1'b0;
        pending_q <= 1'b1;
        pc_q      <= pc_q + ADDR_W'(4);
      end else if (!req_q && !pending_q && buf_free) begin
        req_q <= 1'b1;
      end
      if (rsp_hit) begin
        pending_q <= 1'b0;
      end
      // Retire frees the slot, a new word fills it
      if (instr_done_i) begin
        valid_q <= 1'b0;
      end
      if (rsp_hit) begin
        valid_q <= 1'b1;
      end
    end
  end

  // Instruction word
  always_ff @(posedge clk_i) begin
    if (rsp_hit) begin
      instr_q <= fetch_rsp_i.rdata;
    end
  end

  assign fetch_req_o     = req_q;
  assign fetch_payload_o = '{we: 1'b0, addr: pc_q, wdata: '0};
  assign instr_valid_o   = valid_q;
  assign instr_o         = instr_q;

  // Address must not move while the arbiter makes us wait
  a_fetch_hold : assert property (@(posedge clk_i) disable iff (reset_i)
    fetch_req_o && !fetch_gnt_i |=> fetch_req_o && $stable(fetch_payload_o));

endmodule

`default_nettype wire

/* core/load_store_unit.sv */
`default_nettype none

module load_store_unit (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              lsu_start_i,
  input  logic              lsu_store_i,
  input  logic [31:0]       lsu_addr_i,
  input  logic [31:0]       lsu_wdata_i,
  output logic              lsu_done_o,
  output logic [31:0]       lsu_rdata_o,
  output logic              data_req_o,
  output bus_pkg::bus_req_t data_payload_o,
  input  logic              data_gnt_i,
  input  logic              data_rvalid_i,
  input  bus_pkg::bus_rsp_t data_rsp_i
);
  import bus_pkg::*;

  logic     req_q;
  logic     wait_q;
  bus_req_t payload_q;

  // Request phase, then response phase
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_q  <= 1'b0;
      wait_q <= 1'b0;
    end else begin
      if (lsu_start_i) begin
        req_q <= 1'b1;
      end else if (req_q && data_gnt_i) begin
        req_q  <= 1'b0;
        wait_q <= 1'b1;
      end
      if (wait_q && data_rvalid_i) begin
        wait_q <= 1'b0;
      end
    end
  end

  // Latched once, held through the gnt wait
  always_ff @(posedge clk_i) begin
    if (lsu_start_i) begin
      payload_q <= '{we: lsu_store_i, addr: lsu_addr_i, wdata: lsu_wdata_i};
    end
  end

  assign data_req_o     = req_q;
  assign data_payload_o = payload_q;

  // Done on rvalid, loads and stores alike
  assign lsu_done_o  = wait_q && data_rvalid_i;
  assign lsu_rdata_o = data_rsp_i.rdata;

  // Execute must not start a second access before the first one ends
  a_lsu_single : assert property (@(posedge clk_i) disable iff (reset_i)
    lsu_start_i |-> !req_q && !wait_q);

endmodule

`default_nettype wire

/* core/register_file.sv */
`default_nettype none

module register_file (
  input  logic               clk_i,
  input  logic               reset_i,
  input  isa_pkg::reg_addr_t raddr_a_i,
  input  isa_pkg::reg_addr_t raddr_b_i,
  output logic [31:0]        rdata_a_o,
  output logic [31:0]        rdata_b_o,
  input  logic               we_i,
  input  isa_pkg::reg_addr_t waddr_i,
  input  logic [31:0]        wdata_i
);

  // x1 to x31, x0 has no storage
  logic [31:0] regs_q [31:1];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      // Writes to x0 dropped here
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // x0 reads as zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

`default_nettype wire

/* design/bus_arbiter.sv */
`default_nettype none

module bus_arbiter (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              fetch_req_i,
  input  bus_pkg::bus_req_t fetch_payload_i,
  output logic              fetch_gnt_o,
  output logic              fetch_rvalid_o,
  output bus_pkg::bus_rsp_t fetch_rsp_o,
  input  logic              data_req_i,
  input  bus_pkg::bus_req_t data_payload_i,
  output logic              data_gnt_o,
  output logic              data_rvalid_o,
  output bus_pkg::bus_rsp_t data_rsp_o,
  output logic              bus_req_o,
  output bus_pkg::bus_req_t bus_req_payload_o,
  input  logic              bus_gnt_i,
  input  logic              bus_rvalid_i,
  input  bus_pkg::bus_rsp_t bus_rsp_i
);
  import bus_pkg::*;

  requester_e owner_q;
  requester_e sel;
  logic       busy_q;
  logic       pend_q;

  ////////////////////
  // Selection
  ////////////////////

  // Keep the choice while a request waits or a response is due
  assign sel = (busy_q || pend_q) ? owner_q : (data_req_i ? REQ_DATA : REQ_FETCH);

  assign bus_req_o         = !busy_q && ((sel == REQ_DATA) ? data_req_i : fetch_req_i);
  assign bus_req_payload_o = (sel == REQ_DATA) ? data_payload_i : fetch_payload_i;

  // gnt and rvalid go only to the owner
  assign fetch_gnt_o    = bus_req_o && bus_gnt_i && (sel == REQ_FETCH);
  assign data_gnt_o     = bus_req_o && bus_gnt_i && (sel == REQ_DATA);
  assign fetch_rvalid_o = busy_q && bus_rvalid_i && (owner_q == REQ_FETCH);
  assign data_rvalid_o  = busy_q && bus_rvalid_i && (owner_q == REQ_DATA);
  assign fetch_rsp_o    = bus_rsp_i;
  assign data_rsp_o     = bus_rsp_i;

  ////////////////////
  // Ownership
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      owner_q <= REQ_FETCH;
      busy_q  <= 1'b0;
      pend_q  <= 1'b0;
    end else begin
      if (bus_req_o) begin
        owner_q <= sel;
        pend_q  <= !bus_gnt_i;
        busy_q  <= bus_gnt_i;
      end else if (busy_q && bus_rvalid_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  // Memory side may only answer a granted transaction
  a_no_stray_rvalid : assert property (@(posedge clk_i) disable iff (reset_i)
    bus_rvalid_i |-> busy_q);

endmodule

`default_nettype wire

/* design/mini_core.sv */
`default_nettype none

module mini_core #(
  parameter logic [bus_pkg::ADDR_W-1:0] BOOT_ADDR = 32'h0000_0000
) (
  input  logic              clk_i,
  input  logic              reset_i,
  output logic              bus_req_o,
  output bus_pkg::bus_req_t bus_req_payload_o,
  input  logic              bus_gnt_i,
  input  logic              bus_rvalid_i,
  input  bus_pkg::bus_rsp_t bus_rsp_i
);
  import bus_pkg::*;
  import isa_pkg::*;

  // Fetch side of the arbiter
  logic        fetch_req;
  bus_req_t    fetch_payload;
  logic        fetch_gnt;
  logic        fetch_rvalid;
  bus_rsp_t    fetch_rsp;
  // Data side of the arbiter
  logic        data_req;
  bus_req_t    data_payload;
  logic        data_gnt;
  logic        data_rvalid;
  bus_rsp_t    data_rsp;
  // Fetch to decode and execute
  logic        instr_valid;
  logic [31:0] instr;
  logic        instr_done;
  decoded_t    decoded;
  // Register file
  logic [31:0] rdata_a;
  logic [31:0] rdata_b;
  logic        rf_we;
  reg_addr_t   rf_waddr;
  logic [31:0] rf_wdata;
  // Execute to LSU
  logic        lsu_start;
  logic        lsu_store;
  logic [31:0] lsu_addr;
  logic [31:0] lsu_wdata;
  logic        lsu_done;
  logic [31:0] lsu_rdata;

  ////////////////////
  // Front end
  ////////////////////

  fetch_unit #(.BOOT_ADDR(BOOT_ADDR)) u_fetch_unit (
    .clk_i, .reset_i,
    .fetch_req_o    (fetch_req),    .fetch_payload_o (fetch_payload),
    .fetch_gnt_i    (fetch_gnt),    .fetch_rvalid_i  (fetch_rvalid),
    .fetch_rsp_i    (fetch_rsp),    .instr_done_i    (instr_done),
    .instr_valid_o  (instr_valid),  .instr_o         (instr)
  );

  decoder u_decoder (
    .instr_i   (instr),
    .decoded_o (decoded)
  );

  register_file u_register_file (
    .clk_i, .reset_i,
    .raddr_a_i (decoded.rs1), .raddr_b_i (decoded.rs2),
    .rdata_a_o (rdata_a),     .rdata_b_o (rdata_b),
    .we_i      (rf_we),       .waddr_i   (rf_waddr),  .wdata_i (rf_wdata)
  );

  ////////////////////
  // Back end
  ////////////////////

  execute_unit u_execute_unit (
    .clk_i, .reset_i,
    .instr_valid_i (instr_valid), .decoded_i   (decoded),
    .rdata_a_i     (rdata_a),     .rdata_b_i   (rdata_b),
    .rf_we_o       (rf_we),       .rf_waddr_o  (rf_waddr),  .rf_wdata_o (rf_wdata),
    .instr_done_o  (instr_done),
    .lsu_start_o   (lsu_start),   .lsu_store_o (lsu_store),
    .lsu_addr_o    (lsu_addr),    .lsu_wdata_o (lsu_wdata),
    .lsu_done_i    (lsu_done),    .lsu_rdata_i (lsu_rdata)
  );

  load_store_unit u_load_store_unit (
    .clk_i, .reset_i,
    .lsu_start_i  (lsu_start),    .lsu_store_i    (lsu_store),
    .lsu_addr_i   (lsu_addr),     .lsu_wdata_i    (lsu_wdata),
    .lsu_done_o   (lsu_done),     .lsu_rdata_o    (lsu_rdata),
    .data_req_o   (data_req),     .data_payload_o (data_payload),
    .data_gnt_i   (data_gnt),     .data_rvalid_i  (data_rvalid),
    .data_rsp_i   (data_rsp)
  );

  // One bus port shared by both requesters
  bus_arbiter u_bus_arbiter (
    .clk_i, .reset_i,
    .fetch_req_i    (fetch_req),    .fetch_payload_i (fetch_payload),
    .fetch_gnt_o    (fetch_gnt),    .fetch_rvalid_o  (fetch_rvalid),
    .fetch_rsp_o    (fetch_rsp),
    .data_req_i     (data_req),     .data_payload_i  (data_payload),
    .data_gnt_o     (data_gnt),     .data_rvalid_o   (data_rvalid),
    .data_rsp_o     (data_rsp),
    .bus_req_o, .bus_req_payload_o, .bus_gnt_i, .bus_rvalid_i, .bus_rsp_i
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of tb_mini_core, result taken from sim.log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_mini_core -f build.f > build.log 2>&1 \
  || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/Vtb_mini_core > sim.log 2>&1
grep -q "TEST RESULT: FAIL" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "No result in sim.log"; exit 1; }
echo "Simulation passed"

/* testbench/bus_memory_model.sv */
`default_nettype none

module bus_memory_model #(
  parameter int unsigned MEM_WORDS = 512,
  parameter logic [31:0] SEED      = 32'h0000_0001
) (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              req_i,
  input  bus_pkg::bus_req_t payload_i,
  output logic              gnt_o,
  output logic              rvalid_o,
  output bus_pkg::bus_rsp_t rsp_o
);
  timeunit 1ns;
  timeprecision 1ns;
  import bus_pkg::*;

  localparam int unsigned IDX_W = $clog2(MEM_WORDS);

  // Transaction phases
  localparam int PH_IDLE     = 0;
  localparam int PH_GNT_WAIT = 1;
  localparam int PH_RSP_WAIT = 2;

  logic [31:0] mem [MEM_WORDS];
  logic [31:0] lfsr_q;
  int          phase;
  int          count;
  bus_req_t    txn;

  ////////////////////
  // Random delays
  ////////////////////

  // Galois form, shifts right, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return {1'b0, state[31:1]} ^ (state[0] ? 32'h8020_0003 : 32'h0000_0000);
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, output int value);
    value = 0;
    for (int i = 0; i < n; i++) begin
      value  = (value << 1) | int'(lfsr_q[0]);
      lfsr_q = lfsr_step(lfsr_q);
    end
  endtask

  function automatic logic [IDX_W-1:0] word_index(input logic [31:0] addr);
    return addr[IDX_W+1:2];
  endfunction

  // Called by the testbench to place program and data words
  task automatic load_word(input logic [31:0] addr, input logic [31:0] data);
    mem[word_index(addr)] = data;
  endtask

  // Latch the payload at gnt, then pick 1 to 3 cycles until rvalid
  task automatic grant_now();
    gnt_o = 1'b1;
    txn   = payload_i;
    draw_bits(2, count);
    if (count == 0) begin
      count = 1;
    end
    phase = PH_RSP_WAIT;
  endtask

  initial begin
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    rsp_o    = '0;
    lfsr_q   = SEED;
    phase    = PH_IDLE;
    count    = 0;
    // Unused opcode 7f in every fill word, the rest is the word index
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[IDX_W'(i)] = {i[24:0], 7'h7f};
    end
  end

  ////////////////////
  // Bus side
  ////////////////////

  // Driven on the falling edge, sampled by the DUT on the rising one
  always @(negedge clk_i) begin
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    if (reset_i) begin
      phase = PH_IDLE;
    end else begin
      case (phase)
        PH_IDLE: begin
          if (req_i) begin
            // 0 to 3 cycles before gnt
            draw_bits(2, count);
            if (count == 0) begin
              grant_now();
            end else begin
              phase = PH_GNT_WAIT;
            end
          end
        end
        PH_GNT_WAIT: begin
          count--;
          if (count == 0) begin
            grant_now();
          end
        end
        default: begin
          count--;
          if (count == 0) begin
            if (txn.we) begin
              mem[word_index(txn.addr)] = txn.wdata;
            end else begin
              rsp_o.rdata = mem[word_index(txn.addr)];
            end
            rvalid_o = 1'b1;
            phase    = PH_IDLE;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* testbench/tb_mini_core.sv */
`default_nettype none

module tb_mini_core;
  timeunit 1ns;
  timeprecision 1ns;
  import bus_pkg::*;

  localparam logic [31:0] BOOT_ADDR   = 32'h100;
  localparam int unsigned MEM_WORDS   = 512;
  localparam int unsigned NUM_INSTR   = 21;
  localparam int unsigned CYCLE_LIMIT = NUM_INSTR * 20;
  localparam logic [31:0] LFSR_SEED   = 32'hb67ceb9b;

  // RV32I major opcodes
  localparam logic [6:0] OP_LUI   = 7'b0110111;
  localparam logic [6:0] OP_IMM   = 7'b0010011;
  localparam logic [6:0] OP_REG   = 7'b0110011;
  localparam logic [6:0] OP_LOAD  = 7'b0000011;
  localparam logic [6:0] OP_STORE = 7'b0100011;

  // What the loop does with a row
  typedef enum logic [1:0] {
    ROW_PLAIN,
    ROW_LOAD,
    ROW_STORE
  } row_kind_e;

  // addr and data: expected store, or preloaded word for a load
  typedef struct packed {
    row_kind_e   kind;
    logic [31:0] instr;
    logic [31:0] addr;
    logic [31:0] data;
  } prog_row_t;

  logic        clk_i;
  logic        reset_i;
  logic        bus_req_o;
  bus_req_t    bus_req_payload_o;
  logic        bus_gnt_i;
  logic        bus_rvalid_i;
  bus_rsp_t    bus_rsp_i;

  prog_row_t   program_table [NUM_INSTR];
  string       row_name [NUM_INSTR];
  bus_req_t    store_q [$];
  bus_req_t    held_req;
  bit          held_valid = 1'b0;
  bit          reset_seen = 1'b0;
  logic [31:0] expected_pc = BOOT_ADDR;
  int          fetch_count = 0;
  int          handshake_count = 0;
  int          cycle_count = 0;

  mini_core #(.BOOT_ADDR(BOOT_ADDR)) u_mini_core (
    .clk_i, .reset_i, .bus_req_o, .bus_req_payload_o, .bus_gnt_i, .bus_rvalid_i, .bus_rsp_i
  );

  bus_memory_model #(.MEM_WORDS(MEM_WORDS), .SEED(LFSR_SEED)) u_memory (
    .clk_i, .reset_i,
    .req_i    (bus_req_o),    .payload_i (bus_req_payload_o),
    .gnt_o    (bus_gnt_i),    .rvalid_o  (bus_rvalid_i),
    .rsp_o    (bus_rsp_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  ////////////////////
  // Encoders
  ////////////////////

  function automatic logic [31:0] enc_lui(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, OP_LUI};
  endfunction

  function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, OP_IMM};
  endfunction

  function automatic logic [31:0] enc_add(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
    return {7'b0000000, rs2, rs1, 3'b000, rd, OP_REG};
  endfunction

  function automatic logic [31:0] enc_sub(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
    return {7'b0100000, rs2, rs1, 3'b000, rd, OP_REG};
  endfunction

  function automatic logic [31:0] enc_lw(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, OP_LOAD};
  endfunction

  function automatic logic [31:0] enc_sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
  endfunction

  ////////////////////
  // Program table
  ////////////////////

  task automatic set_row(input int idx, input row_kind_e kind, input logic [31:0] instr,
                         input logic [31:0] addr, input logic [31:0] data, input string name);
    program_table[idx] = '{kind: kind, instr: instr, addr: addr, data: data};
    row_name[idx]      = name;
  endtask

  // x2 holds the data base 0x300, wrap-around sums worked out by hand
  task automatic build_table();
    set_row(0,  ROW_PLAIN, enc_lui(5'd1, 20'h12345),         '0, '0, "lui x1");
    set_row(1,  ROW_PLAIN, enc_addi(5'd1, 5'd1, 12'h678),    '0, '0, "addi x1");
    set_row(2,  ROW_PLAIN, enc_addi(5'd2, 5'd0, 12'h300),    '0, '0, "addi x2");
    set_row(3,  ROW_STORE, enc_sw(5'd1, 5'd2, 12'd0), 32'h300, 32'h1234_5678, "sw lui+addi");
    set_row(4,  ROW_PLAIN, enc_addi(5'd3, 5'd0, 12'hfff),    '0, '0, "addi x3 -1");
    set_row(5,  ROW_PLAIN, enc_addi(5'd4, 5'd3, 12'd2),      '0, '0, "addi x4 wrap");
    set_row(6,  ROW_PLAIN, enc_add(5'd5, 5'd1, 5'd3),        '0, '0, "add x5");
    set_row(7,  ROW_STORE, enc_sw(5'd5, 5'd2, 12'd4), 32'h304, 32'h1234_5677, "sw add");
    set_row(8,  ROW_PLAIN, enc_sub(5'd6, 5'd4, 5'd1),        '0, '0, "sub x6");
    set_row(9,  ROW_STORE, enc_sw(5'd6, 5'd2, 12'd8), 32'h308, 32'hedcb_a989, "sw sub");
    set_row(10, ROW_PLAIN, enc_addi(5'd0, 5'd0, 12'd5),      '0, '0, "addi x0");
    set_row(11, ROW_PLAIN, enc_add(5'd0, 5'd1, 5'd1),        '0, '0, "add x0");
    set_row(12, ROW_STORE, enc_sw(5'd0, 5'd2, 12'd12), 32'h30c, 32'h0, "sw x0");
    set_row(13, ROW_LOAD,  enc_lw(5'd7, 5'd2, 12'h040), 32'h340, 32'ha5c3_5a3c, "lw x7");
    set_row(14, ROW_STORE, enc_sw(5'd7, 5'd2, 12'd16), 32'h310, 32'ha5c3_5a3c, "sw loaded");
    set_row(15, ROW_PLAIN, enc_lui(5'd8, 20'hfffff),         '0, '0, "lui x8");
    set_row(16, ROW_PLAIN, enc_addi(5'd8, 5'd8, 12'h800),    '0, '0, "addi x8 -2048");
    set_row(17, ROW_STORE, enc_sw(5'd8, 5'd2, 12'd20), 32'h314, 32'hffff_e800, "sw neg imm");
    // Misaligned, must not reach the bus
    set_row(18, ROW_PLAIN, enc_sw(5'd1, 5'd2, 12'd2),        '0, '0, "sw misaligned");
    set_row(19, ROW_PLAIN, enc_sub(5'd9, 5'd0, 5'd4),        '0, '0, "sub x9");
    set_row(20, ROW_STORE, enc_sw(5'd9, 5'd2, 12'd24), 32'h318, 32'hffff_ffff, "sw sub wrap");
  endtask

  task automatic load_memory();
    for (int i = 0; i < NUM_INSTR; i++) begin
      u_memory.load_word(BOOT_ADDR + 32'(4 * i), program_table[i].instr);
      if (program_table[i].kind == ROW_LOAD) begin
        u_memory.load_word(program_table[i].addr, program_table[i].data);
      end
    end
  endtask

  ////////////////////
  // Checks
  ////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_req(input string name, input bus_req_t expected, input bus_req_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("Fail %s: expected we=%0b addr=%h data=%h, actual we=%0b addr=%h data=%h",
                          name, expected.we, expected.addr, expected.wdata,
                          actual.we, actual.addr, actual.wdata));
    end
  endtask

  task automatic check_addr(input string name, input logic [ADDR_W-1:0] expected,
                            input logic [ADDR_W-1:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("Fail %s: expected addr=%h, actual addr=%h", name, expected, actual));
    end
  endtask

  function automatic bit is_load_addr(input logic [31:0] addr);
    foreach (program_table[i]) begin
      if (program_table[i].kind == ROW_LOAD && program_table[i].addr == addr) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // Sort one handshake into store, load or fetch
  task automatic log_handshake(input bus_req_t req);
    if (handshake_count == 0 && req.we) begin
      abort_run("First bus handshake carries write enable instead of a fetch");
    end
    handshake_count++;
    if (req.we) begin
      store_q.push_back(req);
    end else if (!is_load_addr(req.addr)) begin
      check_addr($sformatf("fetch %0d", fetch_count), expected_pc, req.addr);
      expected_pc += 32'd4;
      fetch_count++;
    end
  endtask

  ////////////////////
  // Bus monitor
  ////////////////////

  always @(posedge clk_i) begin
    if (reset_i) begin
      if (reset_seen && bus_req_o !== 1'b0) begin
        abort_run("Bus request raised while reset is held");
      end
      reset_seen = 1'b1;
      held_valid = 1'b0;
    end else begin
      // A waiting request keeps req and payload until gnt
      if (held_valid) begin
        if (bus_req_o !== 1'b1) begin
          abort_run("Bus request withdrawn before gnt");
        end
        check_req("held payload", held_req, bus_req_payload_o);
      end
      held_valid = bus_req_o && !bus_gnt_i;
      held_req   = bus_req_payload_o;
      if (bus_req_o && bus_gnt_i) begin
        log_handshake(bus_req_payload_o);
      end
    end
  end

  // Watchdog
  always @(posedge clk_i) begin
    if (!reset_i) begin
      cycle_count++;
      if (cycle_count >= CYCLE_LIMIT) begin
        abort_run($sformatf("Timeout, program did not finish after %0d cycles", cycle_count));
      end
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    bus_req_t actual;
    reset_i = 1'b1;
    build_table();
    // Model has filled its memory by the first rising edge
    @(posedge clk_i);
    load_memory();
    repeat (4) @(negedge clk_i);
    reset_i = 1'b0;
    // Stores must come out in program order
    for (int i = 0; i < NUM_INSTR; i++) begin
      if (program_table[i].kind == ROW_STORE) begin
        while (store_q.size() == 0) begin
          @(negedge clk_i);
        end
        actual = store_q.pop_front();
        check_req(row_name[i],
                  '{we: 1'b1, addr: program_table[i].addr, wdata: program_table[i].data},
                  actual);
      end
    end
    // Fill words past the program retire as no-ops
    while (fetch_count < int'(NUM_INSTR) + 2) begin
      @(negedge clk_i);
    end
    if (store_q.size() != 0) begin
      abort_run("Extra store seen after the last expected one");
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire
